//--- rtl/axi_spi_pkg.sv
package axi_spi_pkg;

  // bus and payload widths
  typedef logic [31:0] axi_data_t;
  typedef logic [6:0]  axi_addr_t;   // byte address, word aligned registers
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [7:0]  spi_data_t;
  typedef logic [3:0]  spi_ratio_t;  // half period is 2**ratio aclk cycles

  parameter int fifo_depth_p = 16;

  localparam axi_resp_t resp_okay = 2'b00;

  // register map
  localparam axi_addr_t reg_srr  = 7'h40;
  localparam axi_addr_t reg_cr   = 7'h60;
  localparam axi_addr_t reg_sr   = 7'h64;
  localparam axi_addr_t reg_dtr  = 7'h68;
  localparam axi_addr_t reg_drr  = 7'h6C;
  localparam axi_addr_t reg_ssr  = 7'h70;
  localparam axi_addr_t reg_tfor = 7'h74;
  localparam axi_addr_t reg_rfor = 7'h78;
  localparam axi_addr_t reg_rclk = 7'h7C;  // custom clock ratio

  // control bits
  localparam int cr_enable_bit    = 1;
  localparam int cr_lsb_first_bit = 9;

  // status bits
  localparam int sr_rx_empty_bit = 0;
  localparam int sr_rx_full_bit  = 1;
  localparam int sr_tx_empty_bit = 2;
  localparam int sr_tx_full_bit  = 3;

  // reset values and magic words
  localparam axi_data_t  cr_init       = 32'h0000_0000;
  localparam axi_data_t  ssr_init      = 32'h0000_0001;  // slave deselected
  localparam spi_ratio_t rclk_init     = 4'h0;
  localparam axi_data_t  srr_key       = 32'h0000_000A;
  localparam axi_data_t  unmapped_data = 32'h6162_6364;

  typedef enum logic {
    wr_idle,
    wr_resp
  } wr_state_e;

  typedef enum logic {
    rd_idle,
    rd_resp
  } rd_state_e;

  typedef enum logic [1:0] {
    eng_idle,
    eng_shift,
    eng_done
  } eng_state_e;

endpackage

//--- rtl/spi_fifo.sv
module spi_fifo
  import axi_spi_pkg::*;
#(
  parameter int fifo_depth_p = axi_spi_pkg::fifo_depth_p
) (
  input  logic      axi_aclk_i,
  input  logic      axi_aresetn_i,
  input  logic      flush_i,
  input  logic      push_i,
  input  logic      pop_i,
  input  spi_data_t data_i,
  output spi_data_t data_o,
  output logic      full_o,
  output logic      empty_o,
  output logic [$clog2(fifo_depth_p+1)-1:0] count_o
);

  localparam int ptr_w = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;

  spi_data_t        mem [fifo_depth_p];
  logic [ptr_w-1:0] wr_ptr, rd_ptr;
  logic             do_push, do_pop;

  assign do_push = push_i && !full_o;   // push on full is dropped
  assign do_pop  = pop_i && !empty_o;   // pop on empty is ignored

  assign full_o  = (count_o == fifo_depth_p);
  assign empty_o = (count_o == '0);
  assign data_o  = mem[rd_ptr];         // head entry

  always_ff @(posedge axi_aclk_i) begin
    if (do_push && !flush_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else if (flush_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth_p - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth_p - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_o <= count_o + 1'b1;
      end else if (do_pop && !do_push) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

endmodule

//--- rtl/spi_master_engine.sv
module spi_master_engine
  import axi_spi_pkg::*;
(
  input  logic       axi_aclk_i,
  input  logic       axi_aresetn_i,
  input  logic       soft_rst_i,
  input  logic       enable_i,
  input  logic       lsb_first_i,
  input  logic       cs_n_sel_i,
  input  spi_ratio_t ratio_i,
  input  spi_data_t  tx_data_i,
  input  logic       tx_empty_i,
  output logic       tx_pop_o,
  output spi_data_t  rx_data_o,
  output logic       rx_push_o,
  input  logic       rx_full_i,
  output logic       spi_clk_o,
  output logic       spi_cs_n_o,
  output logic       spi_mosi_o,
  input  logic       spi_miso_i
);

  eng_state_e  state;
  logic [15:0] div_cnt;
  logic [15:0] div_lim;   // aclk cycles per spi_clk half period, minus one
  logic        half_tick;
  logic [2:0]  bit_cnt;
  spi_data_t   tx_sh;
  logic        lsb_q;     // byte order held for the whole byte

  assign div_lim   = (16'd1 << ratio_i) - 16'd1;
  assign half_tick = (div_cnt == div_lim);

  assign tx_pop_o   = (state == eng_idle) && enable_i && !tx_empty_i;
  assign rx_push_o  = (state == eng_done) && !rx_full_i;  // lost when rx fifo is full
  assign spi_cs_n_o = !((state != eng_idle) && !cs_n_sel_i);
  assign spi_mosi_o = (state == eng_shift) && (lsb_q ? tx_sh[0] : tx_sh[7]);

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state     <= eng_idle;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      spi_clk_o <= 1'b0;
      lsb_q     <= 1'b0;
    end else if (soft_rst_i) begin
      state     <= eng_idle;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      spi_clk_o <= 1'b0;
    end else begin
      case (state)
        eng_idle: begin
          div_cnt   <= '0;
          bit_cnt   <= '0;
          spi_clk_o <= 1'b0;
          if (tx_pop_o) begin
            lsb_q <= lsb_first_i;
            state <= eng_shift;
          end
        end
        eng_shift: begin
          if (half_tick) begin
            div_cnt   <= '0;
            spi_clk_o <= !spi_clk_o;
            if (spi_clk_o) begin  // falling edge ends a bit
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7) begin
                state <= eng_done;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        eng_done: state <= eng_idle;
        default:  state <= eng_idle;
      endcase
    end
  end

  // data path, mode 0: shift out on falling edge, sample on rising edge
  always_ff @(posedge axi_aclk_i) begin
    if (tx_pop_o) begin
      tx_sh <= tx_data_i;
    end else if (state == eng_shift && half_tick) begin
      if (spi_clk_o) begin
        tx_sh <= lsb_q ? {1'b0, tx_sh[7:1]} : {tx_sh[6:0], 1'b0};
      end else begin
        rx_data_o <= lsb_q ? {spi_miso_i, rx_data_o[7:1]} : {rx_data_o[6:0], spi_miso_i};
      end
    end
  end

endmodule

//--- rtl/axi_spi_regs.sv
module axi_spi_regs
  import axi_spi_pkg::*;
#(
  parameter int fifo_depth_p = axi_spi_pkg::fifo_depth_p
) (
  input  logic      axi_aclk_i,
  input  logic      axi_aresetn_i,
  input  axi_id_t   axi_awid_i,
  input  axi_addr_t axi_awaddr_i,
  input  logic      axi_awvalid_i,
  output logic      axi_awready_o,
  input  axi_data_t axi_wdata_i,
  input  axi_strb_t axi_wstrb_i,
  input  logic      axi_wvalid_i,
  output logic      axi_wready_o,
  output axi_id_t   axi_bid_o,
  output axi_resp_t axi_bresp_o,
  output logic      axi_bvalid_o,
  input  logic      axi_bready_i,
  input  axi_id_t   axi_arid_i,
  input  axi_addr_t axi_araddr_i,
  input  logic      axi_arvalid_i,
  output logic      axi_arready_o,
  output axi_id_t   axi_rid_o,
  output axi_data_t axi_rdata_o,
  output axi_resp_t axi_rresp_o,
  output logic      axi_rvalid_o,
  input  logic      axi_rready_i,
  output logic      tx_push_o,
  output spi_data_t tx_data_o,
  input  logic      tx_full_i,
  input  logic      tx_empty_i,
  input  logic [$clog2(fifo_depth_p+1)-1:0] tx_count_i,
  output logic      rx_pop_o,
  input  spi_data_t rx_data_i,
  input  logic      rx_full_i,
  input  logic      rx_empty_i,
  input  logic [$clog2(fifo_depth_p+1)-1:0] rx_count_i,
  output logic      enable_o,
  output logic      lsb_first_o,
  output logic      cs_n_sel_o,
  output logic      soft_rst_o,
  output spi_ratio_t ratio_o
);

  wr_state_e  wr_state;
  rd_state_e  rd_state;
  axi_addr_t  wr_addr, rd_addr;  // word aligned
  axi_data_t  wdata_m;           // write data after strobe masking
  axi_data_t  ssr_q;
  axi_data_t  sr, rd_mux;
  logic       wr_is_dtr, wr_go, rd_go, srr_hit;

  assign wr_addr   = {axi_awaddr_i[6:2], 2'b00};
  assign rd_addr   = {axi_araddr_i[6:2], 2'b00};
  assign wr_is_dtr = (wr_addr == reg_dtr);

  // a dtr write waits here while the tx fifo is full
  assign wr_go = (wr_state == wr_idle) && axi_awvalid_i && axi_wvalid_i &&
                 !soft_rst_o && !(wr_is_dtr && tx_full_i);
  assign rd_go = (rd_state == rd_idle) && axi_arvalid_i;

  always_comb begin
    for (int i = 0; i < $bits(axi_strb_t); i++) begin
      wdata_m[8*i +: 8] = axi_wstrb_i[i] ? axi_wdata_i[8*i +: 8] : 8'h00;
    end
  end

  assign tx_push_o  = wr_go && wr_is_dtr;
  assign tx_data_o  = wdata_m[7:0];
  assign rx_pop_o   = rd_go && (rd_addr == reg_drr) && !rx_empty_i;
  assign cs_n_sel_o = ssr_q[0];

  assign axi_bresp_o = resp_okay;
  assign axi_rresp_o = resp_okay;

  // write channel
  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_state      <= wr_idle;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_bvalid_o  <= 1'b0;
      srr_hit       <= 1'b0;
      soft_rst_o    <= 1'b0;
    end else begin
      soft_rst_o <= 1'b0;  // single cycle pulse
      case (wr_state)
        wr_idle: begin
          if (wr_go) begin
            axi_awready_o <= 1'b1;
            axi_wready_o  <= 1'b1;
            axi_bvalid_o  <= 1'b1;
            srr_hit       <= (wr_addr == reg_srr) && (wdata_m == srr_key);
            wr_state      <= wr_resp;
          end
        end
        wr_resp: begin
          axi_awready_o <= 1'b0;
          axi_wready_o  <= 1'b0;
          if (axi_bready_i) begin
            axi_bvalid_o <= 1'b0;
            soft_rst_o   <= srr_hit;  // fires once the response is taken
            srr_hit      <= 1'b0;
            wr_state     <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (wr_go) begin
      axi_bid_o <= axi_awid_i;
    end
  end

  // control registers
  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      enable_o    <= cr_init[cr_enable_bit];
      lsb_first_o <= cr_init[cr_lsb_first_bit];
      ssr_q       <= ssr_init;
      ratio_o     <= rclk_init;
    end else if (soft_rst_o) begin
      enable_o    <= cr_init[cr_enable_bit];
      lsb_first_o <= cr_init[cr_lsb_first_bit];
      ssr_q       <= ssr_init;
      ratio_o     <= rclk_init;
    end else if (wr_go) begin
      case (wr_addr)
        reg_cr: begin
          enable_o    <= wdata_m[cr_enable_bit];
          lsb_first_o <= wdata_m[cr_lsb_first_bit];
        end
        reg_ssr:  ssr_q   <= wdata_m;
        reg_rclk: ratio_o <= wdata_m[$bits(spi_ratio_t)-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    sr                  = '0;
    sr[sr_rx_empty_bit] = rx_empty_i;
    sr[sr_rx_full_bit]  = rx_full_i;
    sr[sr_tx_empty_bit] = tx_empty_i;
    sr[sr_tx_full_bit]  = tx_full_i;
  end

  // read data select
  always_comb begin
    rd_mux = '0;
    case (rd_addr)
      reg_cr: begin
        rd_mux[cr_enable_bit]    = enable_o;
        rd_mux[cr_lsb_first_bit] = lsb_first_o;
      end
      reg_sr:   rd_mux = sr;
      reg_drr:  rd_mux = rx_empty_i ? '0 : axi_data_t'(rx_data_i);
      reg_ssr:  rd_mux = ssr_q;
      reg_tfor: rd_mux = axi_data_t'(tx_count_i);
      reg_rfor: rd_mux = axi_data_t'(rx_count_i);
      reg_rclk: rd_mux = axi_data_t'(ratio_o);
      reg_srr, reg_dtr: rd_mux = '0;  // write only
      default:  rd_mux = unmapped_data;
    endcase
  end

  // read channel
  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rd_state      <= rd_idle;
      axi_arready_o <= 1'b0;
      axi_rvalid_o  <= 1'b0;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (rd_go) begin
            axi_arready_o <= 1'b1;
            axi_rvalid_o  <= 1'b1;
            rd_state      <= rd_resp;
          end
        end
        rd_resp: begin
          axi_arready_o <= 1'b0;
          if (axi_rready_i) begin
            axi_rvalid_o <= 1'b0;
            rd_state     <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (rd_go) begin
      axi_rid_o   <= axi_arid_i;
      axi_rdata_o <= rd_mux;
    end
  end

endmodule

//--- rtl/axi_spi_top.sv
module axi_spi_top
  import axi_spi_pkg::*;
#(
  parameter int fifo_depth_p = axi_spi_pkg::fifo_depth_p
) (
  input  logic      axi_aclk_i,
  input  logic      axi_aresetn_i,
  input  axi_id_t   axi_awid_i,
  input  axi_addr_t axi_awaddr_i,
  input  logic      axi_awvalid_i,
  output logic      axi_awready_o,
  input  axi_data_t axi_wdata_i,
  input  axi_strb_t axi_wstrb_i,
  input  logic      axi_wvalid_i,
  output logic      axi_wready_o,
  output axi_id_t   axi_bid_o,
  output axi_resp_t axi_bresp_o,
  output logic      axi_bvalid_o,
  input  logic      axi_bready_i,
  input  axi_id_t   axi_arid_i,
  input  axi_addr_t axi_araddr_i,
  input  logic      axi_arvalid_i,
  output logic      axi_arready_o,
  output axi_id_t   axi_rid_o,
  output axi_data_t axi_rdata_o,
  output axi_resp_t axi_rresp_o,
  output logic      axi_rvalid_o,
  input  logic      axi_rready_i,
  output logic      spi_clk_o,
  output logic      spi_cs_n_o,
  output logic      spi_mosi_o,
  input  logic      spi_miso_i
);

  localparam int cnt_w = $clog2(fifo_depth_p + 1);

  logic             tx_push, tx_pop, tx_full, tx_empty;
  spi_data_t        tx_data, tx_data_out;
  logic [cnt_w-1:0] tx_count;
  logic             rx_push, rx_pop, rx_full, rx_empty;
  spi_data_t        rx_data, rx_data_out;
  logic [cnt_w-1:0] rx_count;
  logic             enable, lsb_first, cs_n_sel, soft_rst;
  spi_ratio_t       ratio;

  axi_spi_regs #(
    .fifo_depth_p (fifo_depth_p)
  ) axi_spi_regs_i (
    .axi_aclk_i, .axi_aresetn_i,
    .axi_awid_i, .axi_awaddr_i, .axi_awvalid_i, .axi_awready_o,
    .axi_wdata_i, .axi_wstrb_i, .axi_wvalid_i, .axi_wready_o,
    .axi_bid_o, .axi_bresp_o, .axi_bvalid_o, .axi_bready_i,
    .axi_arid_i, .axi_araddr_i, .axi_arvalid_i, .axi_arready_o,
    .axi_rid_o, .axi_rdata_o, .axi_rresp_o, .axi_rvalid_o, .axi_rready_i,
    .tx_push_o   (tx_push),
    .tx_data_o   (tx_data),
    .tx_full_i   (tx_full),
    .tx_empty_i  (tx_empty),
    .tx_count_i  (tx_count),
    .rx_pop_o    (rx_pop),
    .rx_data_i   (rx_data_out),
    .rx_full_i   (rx_full),
    .rx_empty_i  (rx_empty),
    .rx_count_i  (rx_count),
    .enable_o    (enable),
    .lsb_first_o (lsb_first),
    .cs_n_sel_o  (cs_n_sel),
    .soft_rst_o  (soft_rst),
    .ratio_o     (ratio)
  );

  spi_fifo #(
    .fifo_depth_p (fifo_depth_p)
  ) tx_fifo (
    .axi_aclk_i, .axi_aresetn_i,
    .flush_i (soft_rst),
    .push_i  (tx_push),
    .pop_i   (tx_pop),
    .data_i  (tx_data),
    .data_o  (tx_data_out),
    .full_o  (tx_full),
    .empty_o (tx_empty),
    .count_o (tx_count)
  );

  spi_fifo #(
    .fifo_depth_p (fifo_depth_p)
  ) rx_fifo (
    .axi_aclk_i, .axi_aresetn_i,
    .flush_i (soft_rst),
    .push_i  (rx_push),
    .pop_i   (rx_pop),
    .data_i  (rx_data),
    .data_o  (rx_data_out),
    .full_o  (rx_full),
    .empty_o (rx_empty),
    .count_o (rx_count)
  );

  spi_master_engine spi_master_engine_i (
    .axi_aclk_i, .axi_aresetn_i,
    .soft_rst_i  (soft_rst),
    .enable_i    (enable),
    .lsb_first_i (lsb_first),
    .cs_n_sel_i  (cs_n_sel),
    .ratio_i     (ratio),
    .tx_data_i   (tx_data_out),
    .tx_empty_i  (tx_empty),
    .tx_pop_o    (tx_pop),
    .rx_data_o   (rx_data),
    .rx_push_o   (rx_push),
    .rx_full_i   (rx_full),
    .spi_clk_o, .spi_cs_n_o, .spi_mosi_o, .spi_miso_i
  );

endmodule

//--- testbench/axi_spi_checker.sv
module axi_spi_checker (
  input logic axi_aclk_i,
  input logic axi_aresetn_i,
  input logic awvalid_i,
  input logic awready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic spi_cs_n_i
);

  bvalid_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  awready_needs_valid: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    awready_i |-> awvalid_i)
    else $error("awready high without awvalid");

  // slave stays deselected while in reset
  cs_idle_in_reset: assert property (@(posedge axi_aclk_i)
    !axi_aresetn_i |-> spi_cs_n_i)
    else $error("spi_cs_n low during reset");

endmodule

bind axi_spi_top axi_spi_checker axi_spi_checker_i (
  .axi_aclk_i,
  .axi_aresetn_i,
  .awvalid_i  (axi_awvalid_i),
  .awready_i  (axi_awready_o),
  .bvalid_i   (axi_bvalid_o),
  .bready_i   (axi_bready_i),
  .rvalid_i   (axi_rvalid_o),
  .rready_i   (axi_rready_i),
  .spi_cs_n_i (spi_cs_n_o)
);

//--- testbench/tb_axi_spi.sv
module tb_axi_spi
  import axi_spi_pkg::*;
();

  localparam int resp_limit   = 20;   // cycles to wait for a ready
  localparam int loop_rounds  = 3;
  localparam int bytes_max    = 4;
  localparam int byte_cycles  = 16 * 8 + 4;  // 16 half periods at ratio 3 plus start and push
  localparam int stall_cycles = 50;
  localparam int poll_limit   = bytes_max * byte_cycles;
  localparam int watchdog_cycles = loop_rounds * bytes_max * byte_cycles + stall_cycles + 4000;
  localparam axi_data_t cr_mask = (32'd1 << cr_enable_bit) | (32'd1 << cr_lsb_first_bit);

  logic      aclk = 1'b0;
  logic      aresetn;
  axi_id_t   awid, arid, bid, rid;
  axi_addr_t awaddr, araddr;
  axi_data_t wdata, rdata;
  axi_strb_t wstrb;
  axi_resp_t bresp, rresp;
  logic      awvalid, awready, wvalid, wready, bvalid, bready;
  logic      arvalid, arready, rvalid, rready;
  logic      spi_clk, spi_cs_n, spi_mosi;

  logic [31:0] lcg_state;
  axi_data_t   model_cr, model_ssr, model_rclk;
  int          checks, errors;

  logic        spi_clk_q = 1'b0;  // spi_clk at the previous falling aclk edge
  int          clk_high = 0;       // falling aclk edges seen with spi_clk high
  spi_data_t   wire_sh;
  int          wire_bits = 0;
  spi_data_t   wire_bytes[$];      // first bit on spi_mosi lands in bit 7

  axi_spi_top axi_spi_top_i (
    .axi_aclk_i (aclk), .axi_aresetn_i (aresetn),
    .axi_awid_i (awid), .axi_awaddr_i (awaddr), .axi_awvalid_i (awvalid),
    .axi_awready_o (awready), .axi_wdata_i (wdata), .axi_wstrb_i (wstrb),
    .axi_wvalid_i (wvalid), .axi_wready_o (wready), .axi_bid_o (bid),
    .axi_bresp_o (bresp), .axi_bvalid_o (bvalid), .axi_bready_i (bready),
    .axi_arid_i (arid), .axi_araddr_i (araddr), .axi_arvalid_i (arvalid),
    .axi_arready_o (arready), .axi_rid_o (rid), .axi_rdata_o (rdata),
    .axi_rresp_o (rresp), .axi_rvalid_o (rvalid), .axi_rready_i (rready),
    .spi_clk_o (spi_clk), .spi_cs_n_o (spi_cs_n), .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_mosi)  // loopback
  );

  always #4 aclk = !aclk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic axi_data_t apply_strobes(input axi_data_t data, input axi_strb_t strb);
    axi_data_t res;
    for (int i = 0; i < 4; i++) begin
      res[8*i +: 8] = strb[i] ? data[8*i +: 8] : 8'h00;
    end
    return res;
  endfunction

  function automatic spi_data_t reverse_bits(input spi_data_t b);
    spi_data_t res;
    for (int i = 0; i < 8; i++) begin
      res[i] = b[7 - i];
    end
    return res;
  endfunction

  task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // spi bus monitor, outputs only change on the rising aclk edge
  always @(negedge aclk) begin
    if (spi_clk) begin
      clk_high++;
    end else if (spi_clk_q) begin  // spi_clk just fell
      check_data("spi_clk high time", axi_data_t'(clk_high), 32'd1 << model_rclk);
      clk_high = 0;
    end
    if (spi_clk && !spi_clk_q && !spi_cs_n) begin
      wire_sh = {wire_sh[6:0], spi_mosi};
      wire_bits++;
      if (wire_bits == 8) begin
        wire_bytes.push_back(wire_sh);
        wire_bits = 0;
      end
    end
    spi_clk_q = spi_clk;
  end

  // called on a falling edge, returns on a falling edge
  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
    axi_id_t   id;
    axi_data_t m;
    int        waited, delay;
    logic      ok;
    id      = axi_id_t'(next_rand() >> 16);
    delay   = int'(next_rand() >> 30);  // cycles before bready rises
    awid    = id;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    waited  = 0;
    @(negedge aclk);
    while (!awready && waited < resp_limit) begin
      @(negedge aclk);
      waited++;
    end
    checks++;
    ok = awready && wready && bvalid;
    if (!ok) begin
      $display("write to offset %h got no awready, wready and bvalid within %0d cycles",
               addr, resp_limit);
      errors++;
    end
    @(negedge aclk);  // awready seen high at the edge before this one
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (delay) @(negedge aclk);
    bready = 1'b1;
    if (ok) begin
      check_id("axi_bid_o", bid, id);
      check_resp("axi_bresp_o", bresp, resp_okay);
    end
    @(negedge aclk);
    bready = 1'b0;
    m = apply_strobes(data, strb);
    case (addr)
      reg_cr:   model_cr = m & cr_mask;
      reg_ssr:  model_ssr = m;
      reg_rclk: model_rclk = m & 32'h0000_000F;
      default: ;
    endcase
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
    axi_id_t id;
    int      waited, delay;
    logic    ok;
    id      = axi_id_t'(next_rand() >> 16);
    delay   = int'(next_rand() >> 30);  // cycles before rready rises
    arid    = id;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    waited  = 0;
    data    = '0;
    @(negedge aclk);
    while (!arready && waited < resp_limit) begin
      @(negedge aclk);
      waited++;
    end
    checks++;
    ok = arready && rvalid;
    if (!ok) begin
      $display("read of offset %h got no arready and rvalid within %0d cycles", addr, resp_limit);
      errors++;
    end
    @(negedge aclk);
    arvalid = 1'b0;
    repeat (delay) @(negedge aclk);
    rready = 1'b1;
    if (ok) begin
      data = rdata;
      check_id("axi_rid_o", rid, id);
      check_resp("axi_rresp_o", rresp, resp_okay);
    end
    @(negedge aclk);
    rready = 1'b0;
  endtask

  task automatic read_check(input string name, input axi_addr_t addr, input axi_data_t exp);
    axi_data_t got;
    axi_read(addr, got);
    check_data(name, got, exp);
  endtask

  task automatic test_reset_values();
    int        errs0;
    axi_data_t sr_exp;
    errs0  = errors;
    sr_exp = '0;
    sr_exp[sr_tx_empty_bit] = 1'b1;
    sr_exp[sr_rx_empty_bit] = 1'b1;
    read_check("cr", reg_cr, cr_init);
    read_check("ssr", reg_ssr, ssr_init);
    read_check("rclk", reg_rclk, axi_data_t'(rclk_init));
    read_check("sr", reg_sr, sr_exp);
    read_check("tfor", reg_tfor, '0);
    read_check("rfor", reg_rfor, '0);
    read_check("unmapped 0x10", 7'h10, unmapped_data);
    read_check("unmapped 0x44", 7'h44, unmapped_data);
    $display("test reset_values finished with %0d errors", errors - errs0);
  endtask

  task automatic test_reg_access(input string name, input int count);
    int          errs0;
    logic [31:0] rnd;
    axi_addr_t   addr;
    errs0 = errors;
    for (int i = 0; i < count; i++) begin
      rnd = next_rand();
      case (rnd[17:16])
        2'd0:    addr = reg_cr;
        2'd1:    addr = reg_ssr;
        default: addr = reg_rclk;
      endcase
      axi_write(addr, next_rand(), axi_strb_t'(rnd >> 24));
      read_check("cr", reg_cr, model_cr);
      read_check("ssr", reg_ssr, model_ssr);
      read_check("rclk", reg_rclk, model_rclk);
    end
    $display("test %s finished with %0d errors", name, errors - errs0);
  endtask

  task automatic test_loopback();
    int          errs0, n, polls;
    logic [31:0] rnd;
    logic        lsb;
    axi_data_t   rfor, got;
    spi_data_t   exp_b, seen;
    spi_data_t   sent[$];
    errs0 = errors;
    for (int r = 0; r < loop_rounds; r++) begin
      rnd = next_rand();
      n   = 1 + int'(rnd[17:16]);
      lsb = rnd[24];
      sent.delete();
      wire_bytes.delete();
      axi_write(reg_rclk, axi_data_t'(rnd[21:20]), 4'hF);  // ratio 0 to 3
      axi_write(reg_ssr, '0, 4'hF);
      axi_write(reg_cr, (32'd1 << cr_enable_bit) | (32'(lsb) << cr_lsb_first_bit), 4'hF);
      for (int i = 0; i < n; i++) begin
        rnd = next_rand();
        sent.push_back(rnd[23:16]);
        axi_write(reg_dtr, axi_data_t'(rnd[23:16]), 4'h1);
      end
      rfor  = '0;
      polls = 0;
      while (rfor != axi_data_t'(n) && polls < poll_limit) begin
        axi_read(reg_rfor, rfor);
        polls++;
      end
      checks++;
      if (rfor != axi_data_t'(n)) begin
        $display("RFOR stayed at %0d instead of %0d in round %0d", rfor, n, r);
        errors++;
      end
      while (sent.size() > 0) begin
        exp_b = sent.pop_front();
        axi_read(reg_drr, got);
        check_data("drr", got, axi_data_t'(exp_b));
        checks++;
        if (wire_bytes.size() == 0) begin
          $display("no byte seen on spi_mosi for a DTR write in round %0d", r);
          errors++;
        end else begin
          seen = wire_bytes.pop_front();
          check_data("spi_mosi", axi_data_t'(seen),
                     axi_data_t'(lsb ? reverse_bits(exp_b) : exp_b));
        end
      end
      read_check("drr when empty", reg_drr, '0);
    end
    $display("test loopback finished with %0d errors", errors - errs0);
  endtask

  task automatic test_backpressure();
    int        errs0;
    logic      stalled;
    axi_data_t sr_exp;
    errs0  = errors;
    sr_exp = '0;
    sr_exp[sr_tx_full_bit]  = 1'b1;
    sr_exp[sr_rx_empty_bit] = 1'b1;
    axi_write(reg_cr, '0, 4'hF);
    for (int i = 0; i < fifo_depth_p; i++) begin
      axi_write(reg_dtr, next_rand() >> 16, 4'hF);
    end
    read_check("tfor", reg_tfor, axi_data_t'(fifo_depth_p));
    read_check("sr", reg_sr, sr_exp);
    awid    = axi_id_t'(next_rand() >> 16);
    awaddr  = reg_dtr;
    wdata   = next_rand();
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    stalled = 1'b1;
    repeat (stall_cycles) begin
      @(negedge aclk);
      if (awready || wready) begin
        stalled = 1'b0;
      end
    end
    checks++;
    if (!stalled) begin
      $display("a DTR write was accepted while the transmit FIFO was full");
      errors++;
    end
    awvalid = 1'b0;  // give up on the stalled write
    wvalid  = 1'b0;
    bready  = 1'b0;
    @(negedge aclk);
    $display("test backpressure finished with %0d errors", errors - errs0);
  endtask

  task automatic test_soft_reset();
    int errs0;
    errs0 = errors;
    axi_write(reg_srr, 32'h0000_0005, 4'hF);  // wrong key
    read_check("cr", reg_cr, model_cr);
    read_check("ssr", reg_ssr, model_ssr);
    read_check("rclk", reg_rclk, model_rclk);
    read_check("tfor", reg_tfor, axi_data_t'(fifo_depth_p));
    axi_write(reg_cr, 32'd1 << cr_lsb_first_bit, 4'hF);
    axi_write(reg_ssr, 32'h0000_0003, 4'hF);
    axi_write(reg_rclk, 32'h0000_0002, 4'hF);
    axi_write(reg_srr, 32'h0000_000A, 4'hF);
    repeat (2) @(negedge aclk);  // soft reset pulse follows the response
    model_cr   = cr_init;
    model_ssr  = ssr_init;
    model_rclk = axi_data_t'(rclk_init);
    read_check("cr", reg_cr, model_cr);
    read_check("ssr", reg_ssr, model_ssr);
    read_check("rclk", reg_rclk, model_rclk);
    read_check("tfor", reg_tfor, '0);
    read_check("rfor", reg_rfor, '0);
    $display("test soft_reset finished with %0d errors", errors - errs0);
  endtask

  initial begin
    lcg_state  = 32'h8a60;
    checks     = 0;
    errors     = 0;
    model_cr   = cr_init;
    model_ssr  = ssr_init;
    model_rclk = axi_data_t'(rclk_init);
    aresetn = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    test_reset_values();
    test_reg_access("reg_access", 8);
    test_reg_access("id_echo", 4);  // ids are random on every transaction
    test_loopback();
    test_backpressure();
    test_soft_reset();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * 8);
    $display("timeout, the run did not finish within %0d cycles", watchdog_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sources.f
rtl/axi_spi_pkg.sv
rtl/spi_fifo.sv
rtl/spi_master_engine.sv
rtl/axi_spi_regs.sv
rtl/axi_spi_top.sv
testbench/axi_spi_checker.sv
testbench/tb_axi_spi.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_spi \
  -f sources.f -o tb_axi_spi
./obj_dir/tb_axi_spi > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
